//--- Makefile
SRCS := $(shell cat list.f)

all: run

obj_dir/Vtb_frontpanel: $(SRCS) list.f
	verilator --binary --timing --assert -Wno-fatal --top-module tb_frontpanel -f list.f

run: obj_dir/Vtb_frontpanel
	./obj_dir/Vtb_frontpanel | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

//--- fp_pkg.sv
package fp_pkg;

    // ---------------------------------------------------------------------------
    // Bus and data widths
    // ---------------------------------------------------------------------------
    localparam int EP_W          = 16;
    localparam int HOST_ADDR_W   = 8;
    localparam int LOG_CHAN_W    = 5;
    localparam int LOG_DATA_W    = 18;
    localparam int WR_ADDR_W     = 16;
    localparam int WR_DATA_W     = 49;
    localparam int WR_DATA_WORDS = 4;
    localparam int FIFO_COUNT_W  = 11;

    // Logged channels and pipe storage
    localparam int N_LOG      = 8;
    localparam int LOG_IDX_W  = $clog2(N_LOG);
    localparam int PIPE_DEPTH = 1024;

    typedef logic [EP_W-1:0]         ep_word_t;
    typedef logic [HOST_ADDR_W-1:0]  host_addr_t;
    typedef logic [LOG_CHAN_W-1:0]   log_chan_t;
    typedef logic [LOG_DATA_W-1:0]   log_data_t;
    typedef logic [WR_ADDR_W-1:0]    wr_addr_t;
    typedef logic [WR_DATA_W-1:0]    wr_data_t;
    typedef logic [FIFO_COUNT_W-1:0] fifo_count_t;
    typedef logic [LOG_IDX_W-1:0]    log_idx_t;

    // ---------------------------------------------------------------------------
    // Host endpoint map
    // ---------------------------------------------------------------------------
    localparam host_addr_t EP_ADDR_WI      = 8'h00;
    localparam host_addr_t EP_CHAN_WI      = 8'h01;
    // Data0 carries the low 16 bits of the write word
    localparam host_addr_t EP_DATA0_WI     = 8'h02;
    localparam host_addr_t EP_DATA1_WI     = 8'h03;
    localparam host_addr_t EP_DATA2_WI     = 8'h04;
    localparam host_addr_t EP_DATA3_WI     = 8'h05;
    localparam host_addr_t EP_LOG0_WO      = 8'h20;
    localparam host_addr_t EP_PIPE_STAT_WO = 8'h28;
    localparam host_addr_t EP_TRIG         = 8'h40;
    localparam host_addr_t EP_PIPE_PO      = 8'hA0;

    // Bit positions inside the trigger word
    localparam int TRIG_PID_RST    = 0;
    localparam int TRIG_ADC_CSTART = 1;
    localparam int TRIG_WR_EN      = 2;
    localparam int TRIG_DAC_RSET   = 3;

    // Memory write address that selects the pipe channel
    localparam wr_addr_t PIPE_CHAN_ADDR = 16'h00FF;

    // ---------------------------------------------------------------------------
    // Bundled signals
    // ---------------------------------------------------------------------------
    typedef struct packed {
        logic       wr;
        logic       rd;
        host_addr_t addr;
        ep_word_t   wdata;
    } host_bus_t;

    typedef struct packed {
        wr_addr_t  addr;
        log_chan_t chan;
        wr_data_t  data;
    } wr_cmd_t;

    typedef struct packed {
        logic pid_rst;
        logic adc_cstart;
        logic wr_en;
        logic dac_rset;
    } trig_t;

    typedef struct packed {
        logic      dv;
        log_chan_t chan;
        log_data_t data;
    } log_in_t;

endpackage

//--- frontpanel_top.sv
`timescale 1ns/1ps

module frontpanel_top (
    input  logic              sys_clk_in,
    input  logic              sys_rst_out,
    input  fp_pkg::host_bus_t host,
    input  fp_pkg::log_in_t   log_in,
    output fp_pkg::ep_word_t  host_rdata,
    output logic              host_rvalid,
    output fp_pkg::wr_cmd_t   wr_cmd,
    output fp_pkg::trig_t     trig
);

    // Responder read words
    fp_pkg::ep_word_t cap_rdata;
    fp_pkg::ep_word_t pipe_rdata;

    // ---------------------------------------------------------------------------
    // Host write side
    // ---------------------------------------------------------------------------
    wire_in_bank u_wire_in (
        .sys_clk_in  (sys_clk_in),
        .sys_rst_out (sys_rst_out),
        .host        (host),
        .wr_cmd      (wr_cmd),
        .trig        (trig)
    );

    // ---------------------------------------------------------------------------
    // Log read side
    // ---------------------------------------------------------------------------
    // Single-word wire-outs
    log_capture u_capture (
        .sys_clk_in  (sys_clk_in),
        .sys_rst_out (sys_rst_out),
        .log_in      (log_in),
        .host        (host),
        .cap_rdata   (cap_rdata)
    );

    // Block stream of one channel
    log_pipe_out u_pipe_out (
        .sys_clk_in  (sys_clk_in),
        .sys_rst_out (sys_rst_out),
        .log_in      (log_in),
        .wr_cmd      (wr_cmd),
        .trig        (trig),
        .host        (host),
        .pipe_rdata  (pipe_rdata)
    );

    // Registered return path
    host_read_port u_read_port (
        .sys_clk_in  (sys_clk_in),
        .sys_rst_out (sys_rst_out),
        .host        (host),
        .cap_rdata   (cap_rdata),
        .pipe_rdata  (pipe_rdata),
        .host_rdata  (host_rdata),
        .host_rvalid (host_rvalid)
    );

endmodule

//--- host_read_port.sv
`timescale 1ns/1ps

module host_read_port (
    input  logic              sys_clk_in,
    input  logic              sys_rst_out,
    input  fp_pkg::host_bus_t host,
    input  fp_pkg::ep_word_t  cap_rdata,
    input  fp_pkg::ep_word_t  pipe_rdata,
    output fp_pkg::ep_word_t  host_rdata,
    output logic              host_rvalid
);

    fp_pkg::ep_word_t rdata_q;
    logic             rvalid_q;
    fp_pkg::ep_word_t rdata_mux;

    // Idle responders drive zero, so OR is the read mux
    assign rdata_mux = cap_rdata | pipe_rdata;

    // Read data only loads on a strobe
    always_ff @(posedge sys_clk_in) begin
        if (host.rd) begin
            rdata_q <= rdata_mux;
        end
    end

    // Valid pulse one cycle after each strobe
    always_ff @(posedge sys_clk_in) begin
        if (sys_rst_out) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= host.rd;
        end
    end

    assign host_rdata  = rdata_q;
    assign host_rvalid = rvalid_q;

endmodule

//--- list.f
fp_pkg.sv
wire_in_bank.sv
log_capture.sv
pipe_fifo.sv
log_pipe_out.sv
host_read_port.sv
frontpanel_top.sv
tb_frontpanel_sva.sv
tb_frontpanel.sv

//--- log_capture.sv
`timescale 1ns/1ps

module log_capture (
    input  logic              sys_clk_in,
    input  logic              sys_rst_out,
    input  fp_pkg::log_in_t   log_in,
    input  fp_pkg::host_bus_t host,
    output fp_pkg::ep_word_t  cap_rdata
);

    // Latest sample per channel
    fp_pkg::log_data_t cap_q [fp_pkg::N_LOG];

    logic              log_hit;
    fp_pkg::log_idx_t  log_idx;

    fp_pkg::host_addr_t rd_off;
    logic               rd_hit;
    fp_pkg::log_idx_t   rd_idx;

    // ---------------------------------------------------------------------------
    // Sample capture
    // ---------------------------------------------------------------------------
    // Channels at or above N_LOG have no wire-out
    assign log_hit = log_in.dv && (log_in.chan < fp_pkg::N_LOG);
    assign log_idx = log_in.chan[fp_pkg::LOG_IDX_W-1:0];

    always_ff @(posedge sys_clk_in) begin
        if (sys_rst_out) begin
            for (int i = 0; i < fp_pkg::N_LOG; i++) begin
                cap_q[i] <= '0;
            end
        end else if (log_hit) begin
            cap_q[log_idx] <= log_in.data;
        end
    end

    // ---------------------------------------------------------------------------
    // Wire-out read
    // ---------------------------------------------------------------------------
    // Offset wraps for addresses below the window, so one compare covers both ends
    assign rd_off = host.addr - fp_pkg::EP_LOG0_WO;
    assign rd_hit = host.rd && (rd_off < fp_pkg::N_LOG);
    assign rd_idx = rd_off[fp_pkg::LOG_IDX_W-1:0];

    always_comb begin
        cap_rdata = '0;
        if (rd_hit) begin
            // Upper 16 of the 18 sample bits
            cap_rdata = cap_q[rd_idx][fp_pkg::LOG_DATA_W-1 -: fp_pkg::EP_W];
        end
    end

endmodule

//--- log_pipe_out.sv
`timescale 1ns/1ps

module log_pipe_out (
    input  logic              sys_clk_in,
    input  logic              sys_rst_out,
    input  fp_pkg::log_in_t   log_in,
    input  fp_pkg::wr_cmd_t   wr_cmd,
    input  fp_pkg::trig_t     trig,
    input  fp_pkg::host_bus_t host,
    output fp_pkg::ep_word_t  pipe_rdata
);

    // Channel streamed to the pipe
    fp_pkg::log_chan_t pipe_chan_q;

    logic                fifo_push;
    logic                fifo_pop;
    fp_pkg::ep_word_t    fifo_head;
    fp_pkg::fifo_count_t fifo_count;

    logic rd_pipe;
    logic rd_stat;

    // Channel select by a write command to the reserved address
    always_ff @(posedge sys_clk_in) begin
        if (sys_rst_out) begin
            pipe_chan_q <= '0;
        end else if (trig.wr_en && (wr_cmd.addr == fp_pkg::PIPE_CHAN_ADDR)) begin
            pipe_chan_q <= wr_cmd.chan;
        end
    end

    assign fifo_push = log_in.dv && (log_in.chan == pipe_chan_q);

    assign rd_pipe  = host.rd && (host.addr == fp_pkg::EP_PIPE_PO);
    assign rd_stat  = host.rd && (host.addr == fp_pkg::EP_PIPE_STAT_WO);
    assign fifo_pop = rd_pipe;

    pipe_fifo #(
        .depth (fp_pkg::PIPE_DEPTH),
        .width (fp_pkg::EP_W)
    ) u_fifo (
        .sys_clk_in  (sys_clk_in),
        .sys_rst_out (sys_rst_out),
        .push        (fifo_push),
        .push_data   (log_in.data[fp_pkg::LOG_DATA_W-1 -: fp_pkg::EP_W]),
        .pop         (fifo_pop),
        .pop_data    (fifo_head),
        .count       (fifo_count)
    );

    // Read responder returns zero for an empty pipe
    always_comb begin
        pipe_rdata = '0;
        if (rd_pipe && (fifo_count != '0)) begin
            pipe_rdata = fifo_head;
        end else if (rd_stat) begin
            pipe_rdata = fp_pkg::ep_word_t'(fifo_count);
        end
    end

endmodule

//--- pipe_fifo.sv
`timescale 1ns/1ps

module pipe_fifo #(
    parameter int depth = fp_pkg::PIPE_DEPTH,
    parameter int width = fp_pkg::EP_W
) (
    input  logic                sys_clk_in,
    input  logic                sys_rst_out,
    input  logic                push,
    input  fp_pkg::ep_word_t    push_data,
    input  logic                pop,
    output fp_pkg::ep_word_t    pop_data,
    output fp_pkg::fifo_count_t count
);

    localparam int ptr_w = $clog2(depth);

    typedef logic [ptr_w-1:0] ptr_t;

    // Storage
    logic [width-1:0] mem [depth];

    ptr_t                wr_ptr;
    ptr_t                rd_ptr;
    fp_pkg::fifo_count_t count_q;

    logic full;
    logic empty;
    logic push_ok;
    logic pop_ok;

    assign full  = (count_q == fp_pkg::fifo_count_t'(depth));
    assign empty = (count_q == '0);

    // Pops on empty are ignored
    assign pop_ok  = pop && !empty;
    // Full drops the push unless a pop frees the head slot this cycle
    assign push_ok = push && (!full || pop_ok);

    // ---------------------------------------------------------------------------
    // Pointers and fill count
    // ---------------------------------------------------------------------------
    always_ff @(posedge sys_clk_in) begin
        if (sys_rst_out) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == ptr_t'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == ptr_t'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Data write
    always_ff @(posedge sys_clk_in) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Head word is valid whenever count is nonzero
    assign pop_data = mem[rd_ptr];
    assign count    = count_q;

endmodule

//--- tb_frontpanel.sv
`timescale 1ns/1ps

module tb_frontpanel;

    // Tests need about 2300 cycles, mostly the 1030-sample fill and its drain
    localparam int MAX_CYCLES = 5000;

    logic              sys_clk_in;
    logic              sys_rst_out;
    fp_pkg::host_bus_t host;
    fp_pkg::log_in_t   log_in;
    fp_pkg::ep_word_t  host_rdata;
    logic              host_rvalid;
    fp_pkg::wr_cmd_t   wr_cmd;
    fp_pkg::trig_t     trig;

    int cycles = 0;
    int checks = 0;
    int errors = 0;

    // Expected pipe words, oldest first
    fp_pkg::ep_word_t pipe_q [$];

    // Port names match the testbench signals
    frontpanel_top uut (.*);

    initial begin
        sys_clk_in = 1'b0;
        forever #50 sys_clk_in = ~sys_clk_in;
    end

    always @(posedge sys_clk_in) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not complete", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Bus drivers
    // ------------------------------------------------------------------------
    // Inputs change 10 ns after the rising edge
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge sys_clk_in);
            #10;
        end
    endtask

    task automatic apply_reset();
        sys_rst_out = 1'b1;
        idle(3);
        sys_rst_out = 1'b0;
    endtask

    task automatic host_write(input fp_pkg::host_addr_t addr, input fp_pkg::ep_word_t data);
        host.wr    = 1'b1;
        host.addr  = addr;
        host.wdata = data;
        idle(1);
        host.wr = 1'b0;
    endtask

    // One strobe, then wait for the valid pulse
    task automatic host_read(input fp_pkg::host_addr_t addr, output fp_pkg::ep_word_t data);
        int waited = 0;
        host.rd   = 1'b1;
        host.addr = addr;
        idle(1);
        host.rd = 1'b0;
        while (!host_rvalid && waited < 4) begin
            idle(1);
            waited++;
        end
        if (!host_rvalid) begin
            errors++;
            $display("Read of address %h returned no valid pulse", addr);
        end
        data = host_rdata;
    endtask

    task automatic log_sample(input fp_pkg::log_chan_t ch, input fp_pkg::log_data_t d);
        log_in.dv   = 1'b1;
        log_in.chan = ch;
        log_in.data = d;
        idle(1);
        log_in.dv = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    task automatic check_word(input string name, input fp_pkg::ep_word_t got,
                              input fp_pkg::ep_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_cmd(input string name, input fp_pkg::wr_cmd_t got,
                             input fp_pkg::wr_cmd_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_trig(input string name, input fp_pkg::trig_t got,
                              input fp_pkg::trig_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        $display("Test %s finished, %0d errors so far", name, errors);
    endtask

    // Status first, then each queued word in order, then one empty read
    task automatic check_pipe_stream();
        fp_pkg::ep_word_t rd;
        host_read(fp_pkg::EP_PIPE_STAT_WO, rd);
        check_word("pipe status", rd, 16'(pipe_q.size()));
        while (pipe_q.size() > 0) begin
            host_read(fp_pkg::EP_PIPE_PO, rd);
            check_word("pipe data", rd, pipe_q.pop_front());
        end
        host_read(fp_pkg::EP_PIPE_PO, rd);
        check_word("pipe empty read", rd, 16'h0);
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    task automatic test_wire_in();
        fp_pkg::ep_word_t w [6];
        logic [63:0]      flat;
        fp_pkg::wr_cmd_t  exp;
        for (int r = 0; r < 3; r++) begin
            for (int i = 0; i < 6; i++) begin
                w[i] = 16'($urandom);
            end
            host_write(fp_pkg::EP_ADDR_WI, w[0]);
            // Visible the cycle after the write
            check_word("wr_cmd.addr", wr_cmd.addr, w[0]);
            host_write(fp_pkg::EP_CHAN_WI, w[1]);
            host_write(fp_pkg::EP_DATA0_WI, w[2]);
            host_write(fp_pkg::EP_DATA1_WI, w[3]);
            host_write(fp_pkg::EP_DATA2_WI, w[4]);
            host_write(fp_pkg::EP_DATA3_WI, w[5]);
            // Data0 lowest, top word cut at bit 48
            flat     = {w[5], w[4], w[3], w[2]};
            exp.addr = w[0];
            exp.chan = w[1][fp_pkg::LOG_CHAN_W-1:0];
            exp.data = flat[fp_pkg::WR_DATA_W-1:0];
            check_cmd("wr_cmd", wr_cmd, exp);
        end
        report_test("wire-in command");
    endtask

    task automatic test_trigger();
        logic [3:0]    bits;
        fp_pkg::trig_t exp;
        for (int r = 0; r < 6; r++) begin
            bits           = 4'($urandom);
            exp.pid_rst    = bits[fp_pkg::TRIG_PID_RST];
            exp.adc_cstart = bits[fp_pkg::TRIG_ADC_CSTART];
            exp.wr_en      = bits[fp_pkg::TRIG_WR_EN];
            exp.dac_rset   = bits[fp_pkg::TRIG_DAC_RSET];
            host_write(fp_pkg::EP_TRIG, {12'h0, bits});
            check_trig("trig", trig, exp);
            idle(1);
            check_trig("trig", trig, '0);
        end
        report_test("trigger pulse");
    endtask

    task automatic test_log_capture();
        fp_pkg::log_data_t last [fp_pkg::N_LOG];
        fp_pkg::log_data_t d;
        fp_pkg::ep_word_t  rd;
        for (int r = 0; r < 3; r++) begin
            for (int j = 0; j < fp_pkg::N_LOG; j++) begin
                d = 18'($urandom);
                log_sample(5'(j), d);
                last[j] = d;
            end
        end
        // No wire-out for this channel
        log_sample(5'd12, 18'h3FFFF);
        for (int j = 0; j < fp_pkg::N_LOG; j++) begin
            host_read(8'(fp_pkg::EP_LOG0_WO + j), rd);
            check_word("log wire-out", rd, last[j][17:2]);
        end
        host_read(8'h30, rd);
        check_word("unmapped read", rd, 16'h0);
        report_test("log capture");
    endtask

    task automatic test_pipe_select();
        fp_pkg::log_data_t d;
        fp_pkg::log_chan_t ch;
        fp_pkg::ep_word_t  rd;
        fp_pkg::ep_word_t  n;
        host_write(fp_pkg::EP_ADDR_WI, fp_pkg::PIPE_CHAN_ADDR);
        host_write(fp_pkg::EP_CHAN_WI, 16'd3);
        host_write(fp_pkg::EP_TRIG, 16'(1) << fp_pkg::TRIG_WR_EN);
        idle(1);
        // Flush words queued under the old channel
        host_read(fp_pkg::EP_PIPE_STAT_WO, n);
        repeat (int'(n)) host_read(fp_pkg::EP_PIPE_PO, rd);
        for (int i = 0; i < 24; i++) begin
            ch = (i % 3 == 0) ? 5'd3 : 5'($urandom % 8);
            d  = 18'($urandom);
            log_sample(ch, d);
            if (ch == 5'd3) begin
                pipe_q.push_back(d[17:2]);
            end
        end
        check_pipe_stream();
        report_test("pipe channel select");
    endtask

    task automatic test_pipe_full();
        fp_pkg::log_data_t d;
        for (int i = 0; i < 1030; i++) begin
            d = 18'($urandom);
            log_sample(5'd3, d);
            // Last six dropped on full
            if (i < fp_pkg::PIPE_DEPTH) begin
                pipe_q.push_back(d[17:2]);
            end
        end
        check_pipe_stream();
        report_test("pipe full");
    endtask

    task automatic test_reset();
        fp_pkg::trig_t     exp;
        fp_pkg::log_data_t d;
        fp_pkg::ep_word_t  rd;
        exp         = '0;
        exp.pid_rst = 1'b1;
        host_write(fp_pkg::EP_TRIG, 16'(1) << fp_pkg::TRIG_PID_RST);
        check_trig("trig", trig, exp);
        // PID reset leaves capture and pipe running
        d = 18'($urandom);
        log_sample(5'd3, d);
        host_read(8'(fp_pkg::EP_LOG0_WO + 3), rd);
        check_word("log wire-out", rd, d[17:2]);
        host_read(fp_pkg::EP_PIPE_STAT_WO, rd);
        check_word("pipe status", rd, 16'd1);
        apply_reset();
        for (int j = 0; j < fp_pkg::N_LOG; j++) begin
            host_read(8'(fp_pkg::EP_LOG0_WO + j), rd);
            check_word("log wire-out after reset", rd, 16'h0);
        end
        host_read(fp_pkg::EP_PIPE_STAT_WO, rd);
        check_word("pipe status after reset", rd, 16'h0);
        check_cmd("wr_cmd after reset", wr_cmd, '0);
        report_test("reset");
    endtask

    initial begin
        host        = '0;
        log_in      = '0;
        sys_rst_out = 1'b1;
        void'($urandom(88));
        apply_reset();
        test_wire_in();
        test_trigger();
        test_log_capture();
        test_pipe_select();
        test_pipe_full();
        test_reset();
        $display("Summary: 6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- tb_frontpanel_sva.sv
`timescale 1ns/1ps

module tb_frontpanel_sva (
    input logic                sys_clk_in,
    input logic                sys_rst_out,
    input fp_pkg::host_bus_t   host,
    input fp_pkg::trig_t       trig,
    input logic                host_rvalid,
    input fp_pkg::fifo_count_t fifo_count
);

    logic [3:0] trig_bits;

    assign trig_bits = trig;

    // No trigger bit high on two edges in a row
    a_trig_pulse: assert property (@(posedge sys_clk_in) disable iff (sys_rst_out)
        (trig_bits & $past(trig_bits)) == 4'b0)
        else $error("trigger bit held for more than one cycle");

    // Valid tracks the read strobe one cycle late
    a_rvalid: assert property (@(posedge sys_clk_in) disable iff (sys_rst_out)
        host_rvalid == $past(host.rd))
        else $error("host_rvalid does not follow rd");

    a_fifo_count: assert property (@(posedge sys_clk_in) disable iff (sys_rst_out)
        fifo_count <= fp_pkg::fifo_count_t'(fp_pkg::PIPE_DEPTH))
        else $error("FIFO count above depth");

    // Outputs cleared by reset
    a_reset_quiet: assert property (@(posedge sys_clk_in)
        sys_rst_out |=> (trig_bits == 4'b0) && !host_rvalid)
        else $error("trig or host_rvalid active after reset");

endmodule

bind frontpanel_top tb_frontpanel_sva u_sva (
    .sys_clk_in  (sys_clk_in),
    .sys_rst_out (sys_rst_out),
    .host        (host),
    .trig        (trig),
    .host_rvalid (host_rvalid),
    .fifo_count  (u_pipe_out.fifo_count)
);

//--- wire_in_bank.sv
`timescale 1ns/1ps

module wire_in_bank (
    input  logic              sys_clk_in,
    input  logic              sys_rst_out,
    input  fp_pkg::host_bus_t host,
    output fp_pkg::wr_cmd_t   wr_cmd,
    output fp_pkg::trig_t     trig
);

    // Command wire-in registers
    fp_pkg::wr_addr_t                              addr_q;
    fp_pkg::log_chan_t                             chan_q;
    fp_pkg::ep_word_t [fp_pkg::WR_DATA_WORDS-1:0]  data_q;
    // Flat view of the four data words, word 0 lowest
    logic [fp_pkg::WR_DATA_WORDS*fp_pkg::EP_W-1:0] data_flat;

    // Registered trigger pulses
    fp_pkg::trig_t trig_q;

    logic wr_hit_trig;

    assign wr_hit_trig = host.wr && (host.addr == fp_pkg::EP_TRIG);

    // ---------------------------------------------------------------------------
    // Wire-in decode
    // ---------------------------------------------------------------------------
    always_ff @(posedge sys_clk_in) begin
        if (sys_rst_out) begin
            addr_q <= '0;
            chan_q <= '0;
            data_q <= '0;
        end else if (host.wr) begin
            case (host.addr)
                fp_pkg::EP_ADDR_WI:  addr_q    <= host.wdata;
                // Only the low bits name a channel
                fp_pkg::EP_CHAN_WI:  chan_q    <= host.wdata[fp_pkg::LOG_CHAN_W-1:0];
                fp_pkg::EP_DATA0_WI: data_q[0] <= host.wdata;
                fp_pkg::EP_DATA1_WI: data_q[1] <= host.wdata;
                fp_pkg::EP_DATA2_WI: data_q[2] <= host.wdata;
                fp_pkg::EP_DATA3_WI: data_q[3] <= host.wdata;
                default: ;
            endcase
        end
    end

    // ---------------------------------------------------------------------------
    // Trigger pulses
    // ---------------------------------------------------------------------------
    // One cycle wide, cleared on every edge without a trigger write
    always_ff @(posedge sys_clk_in) begin
        if (sys_rst_out) begin
            trig_q <= '0;
        end else begin
            trig_q <= '0;
            if (wr_hit_trig) begin
                trig_q.pid_rst    <= host.wdata[fp_pkg::TRIG_PID_RST];
                trig_q.adc_cstart <= host.wdata[fp_pkg::TRIG_ADC_CSTART];
                trig_q.wr_en      <= host.wdata[fp_pkg::TRIG_WR_EN];
                trig_q.dac_rset   <= host.wdata[fp_pkg::TRIG_DAC_RSET];
            end
        end
    end

    // Assemble the command word
    assign data_flat = data_q;

    assign wr_cmd.addr = addr_q;
    assign wr_cmd.chan = chan_q;
    // Top word truncated to fit the 49-bit data field
    assign wr_cmd.data = data_flat[fp_pkg::WR_DATA_W-1:0];

    assign trig = trig_q;

endmodule
